// ==== Makefile ====
# Verilator build and run for the SoC fabric testbench

TOP := soc_fabric_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f soc_fabric.f --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "No errors" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== soc_fabric.f ====
+incdir+verilog
verilog/soc_fabric_pkg.sv
verilog/obi_target_demux.sv
verilog/obi_rsp_fifo.sv
verilog/sram_bank.sv
verilog/gpio_regs.sv
verilog/soc_fabric_top.sv
verification/soc_fabric_tb.sv

// ==== verification/soc_fabric_tb.sv ====
// Testbench for soc_fabric_top. SRAM is read only at words written first; writes check err only.
`include "soc_fabric_config.svh"
`default_nettype none

module soc_fabric_tb;

  localparam logic [31:0] sram_end = `SOC_SRAM_BASE + 32'(`SOC_SRAM_WORDS * 4);
  localparam logic [31:0] gpio_end = `SOC_GPIO_BASE + `SOC_GPIO_SIZE;
  localparam int n_planned = 130;

  logic        clk_i, arst_n_i, req_i, we_i, rready_i;
  logic [3:0]  be_i;
  logic [31:0] addr_i, wdata_i;
  logic        gnt_o, rvalid_o, err_o;
  logic [31:0] rdata_o;
  logic [15:0] gpio_i, gpio_o, gpio_out_en_o, gpio_in_sync_o;

  // Reference state
  logic [31:0] sram_m [`SOC_SRAM_WORDS];
  logic [15:0] dir_m, out_m, gpio_in_m;
  logic [31:0] lfsr;
  logic [33:0] exp_q [$];
  int          grant_cyc_q [$];
  logic        lat_q [$];
  int          word_idx [16];
  int          errors, checks, n_grant, n_pop, cyc;
  logic        rr_random, lat_mode, hold_q, hold_err;
  logic [31:0] hold_data;

  soc_fabric_top dut (
    .clk_i, .arst_n_i, .req_i, .we_i, .be_i, .addr_i, .wdata_i, .gnt_o,
    .rvalid_o, .rdata_o, .err_o, .rready_i,
    .gpio_i, .gpio_o, .gpio_out_en_o, .gpio_in_sync_o
  );

  always #4 clk_i = ~clk_i;

  // Galois LFSR stepped once per bit
  function logic next_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'hA300_0000;
    return b;
  endfunction

  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = 32'h0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  // Expected response as {check_data, err, rdata}
  // Writes also update the model
  function logic [33:0] expect_rsp(input logic we, input logic [3:0] be,
                                   input logic [31:0] addr, input logic [31:0] wdata);
    int w;
    if (addr >= `SOC_SRAM_BASE && addr < sram_end) begin
      w = int'((addr - `SOC_SRAM_BASE) >> 2);
      if (!we) return {2'b10, sram_m[w]};
      for (int b = 0; b < 4; b++) if (be[b]) sram_m[w][8*b +: 8] = wdata[8*b +: 8];
      return 34'h0;
    end else if (addr >= `SOC_GPIO_BASE && addr < gpio_end) begin
      if (we) begin
        for (int b = 0; b < 2; b++) begin
          if (be[b] && addr[3:2] == 2'd0) dir_m[8*b +: 8] = wdata[8*b +: 8];
          if (be[b] && addr[3:2] == 2'd1) out_m[8*b +: 8] = wdata[8*b +: 8];
        end
        return 34'h0;
      end
      case (addr[3:2])
        2'd0:    return {2'b10, 16'h0, dir_m};
        2'd1:    return {2'b10, 16'h0, out_m};
        2'd2:    return {2'b10, 16'h0, gpio_in_m};
        default: return {2'b10, 32'h0};
      endcase
    end
    return {2'b11, `SOC_ERR_RDATA};
  endfunction

  // ------------------------------------------------
  // Comparing process
  // ------------------------------------------------
  always @(posedge clk_i) begin
    logic [33:0] e;
    int          g;
    logic        lf;
    cyc = cyc + 1;
    if (arst_n_i) begin
      checks++;
      assert (gnt_o == (req_i && (n_grant - n_pop) < `SOC_RSP_DEPTH)) else begin
        $display("ERROR %0t gnt_o got %b exp %b", $time, gnt_o,
                 req_i && (n_grant - n_pop) < `SOC_RSP_DEPTH);
        errors++;
      end
      if (hold_q) begin
        checks++;
        assert (rvalid_o && rdata_o == hold_data && err_o == hold_err) else begin
          $display("Response changed or vanished while rready_i was low at %0t", $time);
          errors++;
        end
      end
      hold_q = rvalid_o && !rready_i;
      hold_data = rdata_o;
      hold_err = err_o;
      if (rvalid_o && rready_i) begin
        if (exp_q.size() == 0) begin
          $display("Response consumed with no granted request at %0t", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          g = grant_cyc_q.pop_front();
          lf = lat_q.pop_front();
          n_pop++;
          checks++;
          assert (err_o == e[32]) else begin
            $display("ERROR %0t err_o got %b exp %b", $time, err_o, e[32]);
            errors++;
          end
          if (e[33]) begin
            assert (rdata_o == e[31:0]) else begin
              $display("ERROR %0t rdata_o got %h exp %h", $time, rdata_o, e[31:0]);
              errors++;
            end
          end
          if (lf) begin
            assert (cyc - g == 2) else begin
              $display("ERROR %0t rvalid_o latency got %0d exp 2", $time, cyc - g);
              errors++;
            end
          end
        end
      end
      if (req_i && gnt_o) begin
        lat_q.push_back(lat_mode && (n_grant == n_pop));
        exp_q.push_back(expect_rsp(we_i, be_i, addr_i, wdata_i));
        grant_cyc_q.push_back(cyc);
        n_grant++;
      end
    end
  end

  // Manager side back-pressure
  always @(posedge clk_i) rready_i <= rr_random ? next_bit() : 1'b1;

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------
  task automatic send(input logic we, input logic [3:0] be, input logic [31:0] addr,
                      input logic [31:0] wdata);
    req_i   <= 1'b1;
    we_i    <= we;
    be_i    <= be;
    addr_i  <= addr;
    wdata_i <= wdata;
    do @(posedge clk_i); while (!gnt_o);
  endtask

  task automatic idle(input int n);
    req_i <= 1'b0;
    repeat (n) @(posedge clk_i);
  endtask

  task automatic drain();
    req_i <= 1'b0;
    do @(posedge clk_i); while (exp_q.size() != 0);
  endtask

  task automatic check_pins(input logic [15:0] got, input logic [15:0] exp, input string name);
    checks++;
    assert (got == exp) else begin
      $display("ERROR %0t %s got %h exp %h", $time, name, got, exp);
      errors++;
    end
  endtask

  function logic [31:0] sram_addr(input int w);
    return `SOC_SRAM_BASE + 32'(w * 4);
  endfunction

  // Watchdog
  initial begin
    #(n_planned * 20 * 8 + 16 * 8);
    $display("Watchdog expired with %0d responses still expected", exp_q.size());
    $display("Errors found");
    $finish;
  end

  initial begin
    logic [1:0] kind;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    req_i = 1'b0;
    we_i = 1'b0;
    be_i = 4'h0;
    addr_i = 32'h0;
    wdata_i = 32'h0;
    rready_i = 1'b1;
    gpio_i = 16'h0;
    lfsr = 32'he4b324d8;
    errors = 0;
    checks = 0;
    n_grant = 0;
    n_pop = 0;
    cyc = 0;
    rr_random = 1'b0;
    lat_mode = 1'b0;
    hold_q = 1'b0;
    hold_err = 1'b0;
    hold_data = 32'h0;
    dir_m = 16'h0;
    out_m = 16'h0;
    gpio_in_m = 16'h0;
    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_pins({15'h0, rvalid_o}, 16'h0, "rvalid_o");
    check_pins(gpio_o, 16'h0, "gpio_o");
    check_pins(gpio_out_en_o, 16'h0, "gpio_out_en_o");

    // SRAM fill, random byte merges and read back
    for (int i = 0; i < 16; i++) word_idx[i] = i * 16 + int'(rand_bits(4));
    for (int i = 0; i < 16; i++) send(1'b1, 4'hF, sram_addr(word_idx[i]), rand_bits(32));
    for (int i = 0; i < 16; i++) begin
      send(1'b1, 4'(rand_bits(4)), sram_addr(word_idx[i]), rand_bits(32));
    end
    for (int i = 0; i < 16; i++) send(1'b0, 4'hF, sram_addr(word_idx[i]), 32'h0);
    drain();

    // GPIO registers and inputs
    send(1'b1, 4'h3, `SOC_GPIO_BASE, 32'hFFFF_A5C3);
    send(1'b1, 4'hF, `SOC_GPIO_BASE + 32'h4, 32'h1234_3C5A);
    idle(1);
    check_pins(gpio_out_en_o, 16'hA5C3, "gpio_out_en_o");
    check_pins(gpio_o, 16'h3C5A, "gpio_o");
    send(1'b1, 4'h1, `SOC_GPIO_BASE + 32'h4, 32'h0000_00E7);
    send(1'b0, 4'hF, `SOC_GPIO_BASE, 32'h0);
    send(1'b0, 4'hF, `SOC_GPIO_BASE + 32'h4, 32'h0);
    send(1'b0, 4'hF, `SOC_GPIO_BASE + 32'hC, 32'h0);
    gpio_i <= 16'h9D27;
    gpio_in_m = 16'h9D27;
    idle(4);
    check_pins(gpio_in_sync_o, 16'h9D27, "gpio_in_sync_o");
    send(1'b1, 4'hF, `SOC_GPIO_BASE + 32'h8, 32'h0000_FFFF);
    send(1'b0, 4'hF, `SOC_GPIO_BASE + 32'h8, 32'h0);
    drain();
    check_pins(gpio_o, 16'h3CE7, "gpio_o");

    // Unmapped addresses
    send(1'b0, 4'hF, 32'h0000_0000, 32'h0);
    send(1'b1, 4'hF, sram_end, 32'hDEAD_BEEF);
    send(1'b0, 4'hF, `SOC_GPIO_BASE - 32'h4, 32'h0);
    send(1'b1, 4'hF, gpio_end, 32'h0);
    send(1'b0, 4'hF, 32'h8000_0000 | rand_bits(16), 32'h0);
    send(1'b1, 4'hF, 32'hF000_0000, rand_bits(32));
    drain();

    // Random mix under random back-pressure
    rr_random = 1'b1;
    for (int i = 0; i < 60; i++) begin
      kind = 2'(rand_bits(2));
      case (kind)
        2'd1:    send(next_bit(), 4'(rand_bits(4)), `SOC_GPIO_BASE + (rand_bits(2) << 2),
                      rand_bits(32));
        2'd2:    send(next_bit(), 4'hF, 32'h4000_0000 | (rand_bits(20) << 2), rand_bits(32));
        default: send(next_bit(), 4'(rand_bits(4)), sram_addr(word_idx[rand_bits(4)]),
                      rand_bits(32));
      endcase
      if (next_bit()) idle(1);
    end
    drain();
    rr_random = 1'b0;
    idle(2);

    // Grant to rvalid latency with an empty FIFO
    lat_mode = 1'b1;
    for (int i = 0; i < 6; i++) begin
      send(i[0], 4'hF, sram_addr(word_idx[i]), rand_bits(32));
      drain();
    end
    lat_mode = 1'b0;
    idle(4);

    if (n_pop != n_grant) begin
      $display("Granted %0d requests but consumed %0d responses", n_grant, n_pop);
      errors++;
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/gpio_regs.sv ====
// GPIO direction, output and input registers. The pin count must be a multiple of 8.
`include "soc_fabric_config.svh"
`default_nettype none

module gpio_regs (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`SOC_BE_W-1:0]       be_i,
  input  soc_fabric_pkg::gpio_reg_e  reg_i,
  input  logic [`SOC_DATA_W-1:0]     wdata_i,
  output logic [`SOC_DATA_W-1:0]     rdata_o,
  input  logic [`SOC_GPIO_COUNT-1:0] gpio_i,
  output logic [`SOC_GPIO_COUNT-1:0] gpio_o,
  output logic [`SOC_GPIO_COUNT-1:0] gpio_out_en_o,
  output logic [`SOC_GPIO_COUNT-1:0] gpio_in_sync_o
);

  logic [`SOC_GPIO_COUNT-1:0] dir_q;
  logic [`SOC_GPIO_COUNT-1:0] out_q;
  logic [`SOC_GPIO_COUNT-1:0] in_meta_q;
  logic [`SOC_GPIO_COUNT-1:0] in_sync_q;

  // ------------------------------------------------
  // Control registers
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (req_i && we_i) begin
      for (int b = 0; b < `SOC_GPIO_COUNT / 8; b++) begin
        if (be_i[b]) begin
          if (reg_i == soc_fabric_pkg::GPIO_DIR) begin
            dir_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end else if (reg_i == soc_fabric_pkg::GPIO_OUT) begin
            out_q[8*b +: 8] <= wdata_i[8*b +: 8];
          end
        end
      end
    end
  end

  // Two-flop input synchronizer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  // Registered read, unused offset gives zero
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      case (reg_i)
        soc_fabric_pkg::GPIO_DIR: rdata_o <= `SOC_DATA_W'(dir_q);
        soc_fabric_pkg::GPIO_OUT: rdata_o <= `SOC_DATA_W'(out_q);
        soc_fabric_pkg::GPIO_IN:  rdata_o <= `SOC_DATA_W'(in_sync_q);
        default:                  rdata_o <= '0;
      endcase
    end
  end

  assign gpio_o         = out_q;
  assign gpio_out_en_o  = dir_q;
  assign gpio_in_sync_o = in_sync_q;

endmodule

`default_nettype wire

// ==== verilog/obi_rsp_fifo.sv ====
// In-order response buffer. Callers must reserve a slot before each push, so it never overflows.
`include "soc_fabric_config.svh"
`default_nettype none

module obi_rsp_fifo (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   rsv_i,
  input  logic                   push_i,
  input  logic [`SOC_DATA_W-1:0] push_rdata_i,
  input  logic                   push_err_i,
  output logic                   slot_free_o,
  output logic                   rvalid_o,
  output logic [`SOC_DATA_W-1:0] rdata_o,
  output logic                   err_o,
  input  logic                   rready_i
);

  localparam int unsigned Depth = `SOC_RSP_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  logic [`SOC_DATA_W-1:0] rdata_mem [Depth];
  logic                   err_mem   [Depth];
  logic [PtrW-1:0]        wr_ptr_q;
  logic [PtrW-1:0]        rd_ptr_q;
  logic [CntW-1:0]        cnt_q;
  logic [CntW-1:0]        rsv_q;
  logic                   pop;

  function automatic logic [PtrW-1:0] ptr_next(input logic [PtrW-1:0] ptr);
    if (ptr == PtrW'(Depth - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  // Reserved slots count as taken until their push lands
  assign slot_free_o = (cnt_q + rsv_q) < Depth;
  assign rvalid_o    = (cnt_q != '0);
  assign rdata_o     = rdata_mem[rd_ptr_q];
  assign err_o       = err_mem[rd_ptr_q];
  assign pop         = rvalid_o & rready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      rsv_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(pop);
      rsv_q <= rsv_q + CntW'(rsv_i) - CntW'(push_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      rdata_mem[wr_ptr_q] <= push_rdata_i;
      err_mem[wr_ptr_q]   <= push_err_i;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/obi_target_demux.sv ====
// Address decode and grant for a single manager. Every subordinate answers one cycle after req.
`include "soc_fabric_config.svh"
`default_nettype none

module obi_target_demux (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  // Manager request channel
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [`SOC_BE_W-1:0]            be_i,
  input  logic [`SOC_ADDR_W-1:0]          addr_i,
  input  logic [`SOC_DATA_W-1:0]          wdata_i,
  output logic                            gnt_o,
  // Response buffer
  input  logic                            slot_free_i,
  output logic                            rsv_o,
  output logic                            push_o,
  output logic [`SOC_DATA_W-1:0]          push_rdata_o,
  output logic                            push_err_o,
  // SRAM bank
  output logic                            sram_req_o,
  output logic                            sram_we_o,
  output logic [`SOC_BE_W-1:0]            sram_be_o,
  output logic [`SOC_SRAM_AW-1:0]         sram_addr_o,
  output logic [`SOC_DATA_W-1:0]          sram_wdata_o,
  input  logic [`SOC_DATA_W-1:0]          sram_rdata_i,
  // GPIO registers
  output logic                            gpio_req_o,
  output logic                            gpio_we_o,
  output logic [`SOC_BE_W-1:0]            gpio_be_o,
  output soc_fabric_pkg::gpio_reg_e       gpio_reg_o,
  output logic [`SOC_DATA_W-1:0]          gpio_wdata_o,
  input  logic [`SOC_DATA_W-1:0]          gpio_rdata_i
);

  logic [`SOC_ADDR_W-1:0]      sram_off;
  logic [`SOC_ADDR_W-1:0]      gpio_off;
  soc_fabric_pkg::bus_target_e tgt;
  soc_fabric_pkg::bus_target_e rsp_tgt_q;
  logic                        rsp_pend_q;
  logic                        fire;

  // ------------------------------------------------
  // Address decode
  // ------------------------------------------------
  assign sram_off = addr_i - `SOC_SRAM_BASE;
  assign gpio_off = addr_i - `SOC_GPIO_BASE;

  always_comb begin
    if (sram_off < (`SOC_SRAM_WORDS * 4)) begin
      tgt = soc_fabric_pkg::TGT_SRAM;
    end else if (gpio_off < `SOC_GPIO_SIZE) begin
      tgt = soc_fabric_pkg::TGT_GPIO;
    end else begin
      tgt = soc_fabric_pkg::TGT_ERR;
    end
  end

  // Grant depends on buffer space only, never on the address
  assign gnt_o = req_i & slot_free_i;
  assign fire  = gnt_o;
  assign rsv_o = fire;

  // Request fan-out, only the selected target sees req
  assign sram_req_o   = fire && (tgt == soc_fabric_pkg::TGT_SRAM);
  assign sram_we_o    = we_i;
  assign sram_be_o    = be_i;
  assign sram_addr_o  = sram_off[`SOC_SRAM_AW+1:2];
  assign sram_wdata_o = wdata_i;

  assign gpio_req_o   = fire && (tgt == soc_fabric_pkg::TGT_GPIO);
  assign gpio_we_o    = we_i;
  assign gpio_be_o    = be_i;
  assign gpio_reg_o   = soc_fabric_pkg::gpio_reg_e'(addr_i[3:2]);
  assign gpio_wdata_o = wdata_i;

  // ------------------------------------------------
  // Response steering
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_pend_q <= 1'b0;
      rsp_tgt_q  <= soc_fabric_pkg::TGT_ERR;
    end else begin
      rsp_pend_q <= fire;
      if (fire) begin
        rsp_tgt_q <= tgt;
      end
    end
  end

  always_comb begin
    case (rsp_tgt_q)
      soc_fabric_pkg::TGT_SRAM: push_rdata_o = sram_rdata_i;
      soc_fabric_pkg::TGT_GPIO: push_rdata_o = gpio_rdata_i;
      default:                  push_rdata_o = `SOC_ERR_RDATA;
    endcase
  end

  assign push_o     = rsp_pend_q;
  assign push_err_o = (rsp_tgt_q == soc_fabric_pkg::TGT_ERR);

endmodule

`default_nettype wire

// ==== verilog/soc_fabric_config.svh ====
// Fixed sizes for the fabric. The GPIO pin count must be a multiple of 8 and at most 32.
`ifndef SOC_FABRIC_CONFIG_SVH
`define SOC_FABRIC_CONFIG_SVH

// Bus widths
`define SOC_DATA_W      32
`define SOC_ADDR_W      32
`define SOC_BE_W        4

// ------------------------------------------------
// Address map
// ------------------------------------------------
`define SOC_SRAM_BASE   32'h1000_0000
`define SOC_SRAM_WORDS  256
`define SOC_SRAM_AW     8

// 4 KiB register window
`define SOC_GPIO_BASE   32'h0300_5000
`define SOC_GPIO_SIZE   32'h0000_1000
`define SOC_GPIO_COUNT  16

// Response path
`define SOC_RSP_DEPTH   2
`define SOC_ERR_RDATA   32'hBADCAB1E

`endif

// ==== verilog/soc_fabric_pkg.sv ====
// Enum types shared by the fabric. Register offsets decode from address bits 3:2 only.
`default_nettype none

package soc_fabric_pkg;

  // ------------------------------------------------
  // Bus targets
  // ------------------------------------------------
  // Error target catches every unmapped address
  typedef enum logic [1:0] {
    TGT_SRAM = 2'd0,
    TGT_GPIO = 2'd1,
    TGT_ERR  = 2'd2
  } bus_target_e;

  // ------------------------------------------------
  // GPIO register offsets
  // ------------------------------------------------
  // Word index inside the GPIO window
  //   0x0 direction, 1 drives the pin
  //   0x4 output value
  //   0x8 synchronized input, read only
  // Offset 0xC is unused and reads as zero
  typedef enum logic [1:0] {
    GPIO_DIR = 2'd0,
    GPIO_OUT = 2'd1,
    GPIO_IN  = 2'd2
  } gpio_reg_e;

endpackage

`default_nettype wire

// ==== verilog/soc_fabric_top.sv ====
// One OBI manager port to SRAM, GPIO and error targets. No IDs, responses return in grant order.
`include "soc_fabric_config.svh"
`default_nettype none

module soc_fabric_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Request channel
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [`SOC_BE_W-1:0]       be_i,
  input  logic [`SOC_ADDR_W-1:0]     addr_i,
  input  logic [`SOC_DATA_W-1:0]     wdata_i,
  output logic                       gnt_o,
  // Response channel
  output logic                       rvalid_o,
  output logic [`SOC_DATA_W-1:0]     rdata_o,
  output logic                       err_o,
  input  logic                       rready_i,
  // GPIO pins
  input  logic [`SOC_GPIO_COUNT-1:0] gpio_i,
  output logic [`SOC_GPIO_COUNT-1:0] gpio_o,
  output logic [`SOC_GPIO_COUNT-1:0] gpio_out_en_o,
  output logic [`SOC_GPIO_COUNT-1:0] gpio_in_sync_o
);

  // Demux to response buffer
  logic                      slot_free;
  logic                      rsv;
  logic                      push;
  logic [`SOC_DATA_W-1:0]    push_rdata;
  logic                      push_err;

  // Subordinate buses
  logic                      sram_req;
  logic                      sram_we;
  logic [`SOC_BE_W-1:0]      sram_be;
  logic [`SOC_SRAM_AW-1:0]   sram_addr;
  logic [`SOC_DATA_W-1:0]    sram_wdata;
  logic [`SOC_DATA_W-1:0]    sram_rdata;
  logic                      gpio_req;
  logic                      gpio_we;
  logic [`SOC_BE_W-1:0]      gpio_be;
  soc_fabric_pkg::gpio_reg_e gpio_reg;
  logic [`SOC_DATA_W-1:0]    gpio_wdata;
  logic [`SOC_DATA_W-1:0]    gpio_rdata;

  // ------------------------------------------------
  // Request side
  // ------------------------------------------------
  obi_target_demux i_demux (
    .clk_i,
    .arst_n_i,
    .req_i,
    .we_i,
    .be_i,
    .addr_i,
    .wdata_i,
    .gnt_o,
    .slot_free_i  ( slot_free  ),
    .rsv_o        ( rsv        ),
    .push_o       ( push       ),
    .push_rdata_o ( push_rdata ),
    .push_err_o   ( push_err   ),
    .sram_req_o   ( sram_req   ),
    .sram_we_o    ( sram_we    ),
    .sram_be_o    ( sram_be    ),
    .sram_addr_o  ( sram_addr  ),
    .sram_wdata_o ( sram_wdata ),
    .sram_rdata_i ( sram_rdata ),
    .gpio_req_o   ( gpio_req   ),
    .gpio_we_o    ( gpio_we    ),
    .gpio_be_o    ( gpio_be    ),
    .gpio_reg_o   ( gpio_reg   ),
    .gpio_wdata_o ( gpio_wdata ),
    .gpio_rdata_i ( gpio_rdata )
  );

  // ------------------------------------------------
  // Subordinates and response buffer
  // ------------------------------------------------
  sram_bank i_sram (
    .clk_i,
    .req_i   ( sram_req   ),
    .we_i    ( sram_we    ),
    .be_i    ( sram_be    ),
    .addr_i  ( sram_addr  ),
    .wdata_i ( sram_wdata ),
    .rdata_o ( sram_rdata )
  );

  gpio_regs i_gpio (
    .clk_i,
    .arst_n_i,
    .req_i   ( gpio_req   ),
    .we_i    ( gpio_we    ),
    .be_i    ( gpio_be    ),
    .reg_i   ( gpio_reg   ),
    .wdata_i ( gpio_wdata ),
    .rdata_o ( gpio_rdata ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o,
    .gpio_in_sync_o
  );

  obi_rsp_fifo i_rsp_fifo (
    .clk_i,
    .arst_n_i,
    .rsv_i        ( rsv        ),
    .push_i       ( push       ),
    .push_rdata_i ( push_rdata ),
    .push_err_i   ( push_err   ),
    .slot_free_o  ( slot_free  ),
    .rvalid_o,
    .rdata_o,
    .err_o,
    .rready_i
  );

endmodule

`default_nettype wire

// ==== verilog/sram_bank.sv ====
// Single-port word memory with one-cycle read latency. Contents are undefined until written.
`include "soc_fabric_config.svh"
`default_nettype none

module sram_bank (
  input  logic                    clk_i,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [`SOC_BE_W-1:0]    be_i,
  input  logic [`SOC_SRAM_AW-1:0] addr_i,
  input  logic [`SOC_DATA_W-1:0]  wdata_i,
  output logic [`SOC_DATA_W-1:0]  rdata_o
);

  logic [`SOC_DATA_W-1:0] mem [`SOC_SRAM_WORDS];

  // ------------------------------------------------
  // Byte-enabled write port
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < `SOC_BE_W; b++) begin
        if (be_i[b]) begin
          mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ------------------------------------------------
  // Read port
  // ------------------------------------------------
  // Read data holds its last value across writes
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem[addr_i];
    end
  end

endmodule

`default_nettype wire
